/* cpu_pkg.sv */
package cpu_pkg;

    // datapath, instruction and register address widths
    localparam int xlen       = 16;
    localparam int reg_addr_w = 3;

    // trace record widths
    localparam int seq_w   = 16;
    localparam int cycle_w = 32;

    // field positions inside a 16-bit instruction word
    localparam int op_w    = 4;
    localparam int op_lsb  = 12;
    localparam int rd_lsb  = 9;
    localparam int rs1_lsb = 6;
    localparam int rs2_lsb = 3;
    localparam int imm_w   = 6;

    // add, sub, and and or read rs1 and rs2 and write rd
    // addi and lw read rs1, write rd and use the signed imm
    // sw stores the rd-field register to rs1 + imm
    // beq compares the rd-field register with rs1
    // and jumps to pc + 1 + imm when they are equal
    typedef enum logic [op_w-1:0] {
        op_nop  = 4'h0,
        op_add  = 4'h1,
        op_sub  = 4'h2,
        op_and  = 4'h3,
        op_or   = 4'h4,
        op_addi = 4'h5,
        op_lw   = 4'h6,
        op_sw   = 4'h7,
        op_beq  = 4'h8,
        op_halt = 4'h9
    } opcode_t;

endpackage

/* fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage #(
    parameter int imem_words = 64,
    parameter int pc_w       = 6
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stall,
    input  logic                     branch_taken,
    input  logic [pc_w-1:0]          branch_target,
    output logic                     if_valid,
    output logic [pc_w-1:0]          if_pc,
    output logic [cpu_pkg::xlen-1:0] if_instr,
    output logic                     fetch_fire
);
    import cpu_pkg::*;

    logic [xlen-1:0] rom [imem_words];
    logic [pc_w-1:0] pc;
    logic            halt_seen;
    logic [xlen-1:0] fetch_word;
    logic            fetch_is_halt;

    initial begin
        $readmemh("program.hex", rom);
    end

    assign fetch_word    = rom[pc];
    assign fetch_is_halt = fetch_word[op_lsb +: op_w] == op_halt;
    // stop issuing once a halt has entered IF/ID
    assign fetch_fire    = !halt_seen && !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= '0;
            halt_seen <= 1'b0;
            if_valid  <= 1'b0;
        end else if (branch_taken) begin
            // any halt fetched here is younger than the branch
            pc        <= branch_target;
            halt_seen <= 1'b0;
            if_valid  <= 1'b0;
        end else if (!stall) begin
            if_valid <= fetch_fire;
            if (fetch_fire) begin
                pc        <= pc + 1'b1;
                halt_seen <= fetch_is_halt;
            end
        end
    end

    // IF/ID payload holds while decode stalls
    always_ff @(posedge clk) begin
        if (!stall) begin
            if_pc    <= pc;
            if_instr <= fetch_word;
        end
    end

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage #(
    parameter int pc_w = 6
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           if_valid,
    input  logic [pc_w-1:0]                if_pc,
    input  logic [cpu_pkg::xlen-1:0]       if_instr,
    input  logic                           branch_taken,
    input  logic                           wb_we,
    input  logic [cpu_pkg::reg_addr_w-1:0] wb_rd,
    input  logic [cpu_pkg::xlen-1:0]       wb_data,
    input  logic                           ex_valid_in,
    input  cpu_pkg::opcode_t               ex_op_in,
    input  logic [cpu_pkg::reg_addr_w-1:0] ex_rd_in,
    output logic                           stall,
    output logic                           id_valid,
    output cpu_pkg::opcode_t               id_op,
    output logic [cpu_pkg::reg_addr_w-1:0] id_rd,
    output logic [cpu_pkg::reg_addr_w-1:0] id_rs1,
    output logic [cpu_pkg::reg_addr_w-1:0] id_rs2,
    output logic [cpu_pkg::xlen-1:0]       id_rs1_data,
    output logic [cpu_pkg::xlen-1:0]       id_rs2_data,
    output logic [cpu_pkg::xlen-1:0]       id_imm,
    output logic [pc_w-1:0]                id_pc
);
    import cpu_pkg::*;

    logic [xlen-1:0]       regs [1 << reg_addr_w];
    opcode_t               op;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       imm;
    logic                  uses_rs1;
    logic                  uses_rs2;
    logic                  writes_rd;
    logic [xlen-1:0]       rs1_val;
    logic [xlen-1:0]       rs2_val;
    logic                  load_in_ex;

    ////////////////////////////////////////////////////////////
    // instruction decode
    ////////////////////////////////////////////////////////////

    assign op  = opcode_t'(if_instr[op_lsb +: op_w]);
    assign rs1 = if_instr[rs1_lsb +: reg_addr_w];
    assign imm = {{(xlen - imm_w){if_instr[imm_w-1]}}, if_instr[imm_w-1:0]};

    always_comb begin
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        writes_rd = 1'b0;
        rs2       = if_instr[rs2_lsb +: reg_addr_w];
        case (op)
            op_add, op_sub, op_and, op_or: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                writes_rd = 1'b1;
            end
            op_addi, op_lw: begin
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
            end
            op_sw, op_beq: begin
                // second source comes from the rd field
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                rs2      = if_instr[rd_lsb +: reg_addr_w];
            end
            default: ;
        endcase
        // non-writers carry rd 0 so forwarding ignores them
        rd = writes_rd ? if_instr[rd_lsb +: reg_addr_w] : '0;
    end

    ////////////////////////////////////////////////////////////
    // register file
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << reg_addr_w); i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // write-back bypass gives write-before-read in one cycle
    assign rs1_val = (rs1 == '0) ? '0 :
                     (wb_we && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 :
                     (wb_we && wb_rd == rs2) ? wb_data : regs[rs2];

    ////////////////////////////////////////////////////////////
    // load-use hazard and ID/EX register
    ////////////////////////////////////////////////////////////

    assign load_in_ex = ex_valid_in && ex_op_in == op_lw && ex_rd_in != '0;
    assign stall      = if_valid && load_in_ex &&
                        ((uses_rs1 && rs1 == ex_rd_in) || (uses_rs2 && rs2 == ex_rd_in));

    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid <= 1'b0;
        end else if (branch_taken || stall) begin
            // bubble
            id_valid <= 1'b0;
        end else begin
            id_valid <= if_valid;
        end
    end

    always_ff @(posedge clk) begin
        id_op       <= op;
        id_rd       <= rd;
        id_rs1      <= rs1;
        id_rs2      <= rs2;
        id_rs1_data <= rs1_val;
        id_rs2_data <= rs2_val;
        id_imm      <= imm;
        id_pc       <= if_pc;
    end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage #(
    parameter int pc_w = 6
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           id_valid,
    input  cpu_pkg::opcode_t               id_op,
    input  logic [cpu_pkg::reg_addr_w-1:0] id_rd,
    input  logic [cpu_pkg::reg_addr_w-1:0] id_rs1,
    input  logic [cpu_pkg::reg_addr_w-1:0] id_rs2,
    input  logic [cpu_pkg::xlen-1:0]       id_rs1_data,
    input  logic [cpu_pkg::xlen-1:0]       id_rs2_data,
    input  logic [cpu_pkg::xlen-1:0]       id_imm,
    input  logic [pc_w-1:0]                id_pc,
    input  logic                           mem_fwd_valid,
    input  logic [cpu_pkg::reg_addr_w-1:0] mem_fwd_rd,
    input  logic [cpu_pkg::xlen-1:0]       mem_fwd_data,
    input  logic                           wb_fwd_valid,
    input  logic [cpu_pkg::reg_addr_w-1:0] wb_fwd_rd,
    input  logic [cpu_pkg::xlen-1:0]       wb_fwd_data,
    output logic                           branch_taken,
    output logic [pc_w-1:0]                branch_target,
    output logic                           ex_valid,
    output cpu_pkg::opcode_t               ex_op,
    output logic [cpu_pkg::reg_addr_w-1:0] ex_rd,
    output logic [cpu_pkg::xlen-1:0]       ex_result,
    output logic [cpu_pkg::xlen-1:0]       ex_store_data,
    output logic [pc_w-1:0]                ex_pc
);
    import cpu_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_out;

    // youngest producer wins, r0 is never forwarded
    function automatic logic [xlen-1:0] forward(input logic [reg_addr_w-1:0] ra,
                                                input logic [xlen-1:0]       rf_val);
        if (ra == '0) begin
            return rf_val;
        end
        if (mem_fwd_valid && mem_fwd_rd == ra) begin
            return mem_fwd_data;
        end
        if (wb_fwd_valid && wb_fwd_rd == ra) begin
            return wb_fwd_data;
        end
        return rf_val;
    endfunction

    always_comb begin
        op_a = forward(id_rs1, id_rs1_data);
        op_b = forward(id_rs2, id_rs2_data);
        case (id_op)
            op_add:                alu_out = op_a + op_b;
            op_sub:                alu_out = op_a - op_b;
            op_and:                alu_out = op_a & op_b;
            op_or:                 alu_out = op_a | op_b;
            op_addi, op_lw, op_sw: alu_out = op_a + id_imm;
            default:               alu_out = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // branch resolution
    ////////////////////////////////////////////////////////////

    assign branch_taken  = id_valid && id_op == op_beq && op_a == op_b;
    assign branch_target = id_pc + 1'b1 + id_imm[pc_w-1:0];

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_op         <= id_op;
        ex_rd         <= id_rd;
        ex_result     <= alu_out;
        ex_store_data <= op_b;
        ex_pc         <= id_pc;
    end

endmodule

/* mem_wb_stage.sv */
`timescale 1ns/1ps

module mem_wb_stage #(
    parameter int pc_w       = 6,
    parameter int dmem_words = 64
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           ex_valid,
    input  cpu_pkg::opcode_t               ex_op,
    input  logic [cpu_pkg::reg_addr_w-1:0] ex_rd,
    input  logic [cpu_pkg::xlen-1:0]       ex_result,
    input  logic [cpu_pkg::xlen-1:0]       ex_store_data,
    input  logic [pc_w-1:0]                ex_pc,
    output logic                           wb_valid,
    output cpu_pkg::opcode_t               wb_op,
    output logic [cpu_pkg::reg_addr_w-1:0] wb_rd,
    output logic [cpu_pkg::xlen-1:0]       wb_data,
    output logic [pc_w-1:0]                wb_pc,
    output logic                           wb_we
);
    import cpu_pkg::*;

    localparam int dmem_aw = (dmem_words > 1) ? $clog2(dmem_words) : 1;

    logic [xlen-1:0]    ram [dmem_words];
    logic [dmem_aw-1:0] addr;
    logic [xlen-1:0]    load_data;

    initial begin
        for (int i = 0; i < dmem_words; i++) begin
            ram[i] = '0;
        end
    end

    // word address wraps at the RAM size
    assign addr      = dmem_aw'(ex_result % dmem_words);
    assign load_data = ram[addr];

    always @(posedge clk) begin
        if (ex_valid && ex_op == op_sw) begin
            ram[addr] <= ex_store_data;
        end
    end

    // MEM/WB register
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_op   <= ex_op;
        wb_rd   <= ex_rd;
        wb_pc   <= ex_pc;
        wb_data <= (ex_op == op_lw) ? load_data : ex_result;
    end

    always_comb begin
        case (wb_op)
            op_add, op_sub, op_and, op_or, op_addi, op_lw: wb_we = wb_valid && wb_rd != '0;
            default:                                       wb_we = 1'b0;
        endcase
    end

endmodule

/* pipeline_trace.sv */
`timescale 1ns/1ps

module pipeline_trace (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        fetch_fire,
    input  logic                        stall,
    input  logic                        branch_taken,
    input  logic                        wb_valid,
    output logic                        retire_valid,
    output logic [cpu_pkg::seq_w-1:0]   retire_seq,
    output logic [cpu_pkg::cycle_w-1:0] retire_fetch_cycle,
    output logic [cpu_pkg::cycle_w-1:0] retire_cycle
);
    import cpu_pkg::*;

    localparam int tag_w = seq_w + cycle_w;

    logic [cycle_w-1:0] cycle;
    logic [seq_w-1:0]   next_seq;
    // each tag is {sequence number, fetch cycle}
    logic [tag_w-1:0]   tag_if;
    logic [tag_w-1:0]   tag_id;
    logic [tag_w-1:0]   tag_ex;
    logic [tag_w-1:0]   tag_mem;
    logic [tag_w-1:0]   tag_wb;
    logic               v_id;
    logic               v_ex;
    logic               v_mem;
    logic               v_wb;

    // every fetch takes a number, squashed ones included
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle    <= '0;
            next_seq <= '0;
        end else begin
            cycle <= cycle + 1'b1;
            if (fetch_fire) begin
                next_seq <= next_seq + 1'b1;
            end
        end
    end

    assign tag_if = {next_seq, cycle};

    ////////////////////////////////////////////////////////////
    // shadow pipeline, same stall and flush rules as the datapath
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            v_id  <= 1'b0;
            v_ex  <= 1'b0;
            v_mem <= 1'b0;
            v_wb  <= 1'b0;
        end else begin
            if (branch_taken) begin
                v_id <= 1'b0;
            end else if (!stall) begin
                v_id <= fetch_fire;
            end
            v_ex  <= v_id && !branch_taken && !stall;
            v_mem <= v_ex;
            v_wb  <= v_mem;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            tag_id <= tag_if;
        end
        tag_ex  <= tag_id;
        tag_mem <= tag_ex;
        tag_wb  <= tag_mem;
    end

    assign retire_valid                     = wb_valid && v_wb;
    assign {retire_seq, retire_fetch_cycle} = tag_wb;
    assign retire_cycle                     = cycle;

endmodule

/* cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
    parameter int  imem_words = 64,
    parameter int  dmem_words = 64,
    localparam int pc_w       = $clog2(imem_words)
) (
    input  logic                           clk,
    input  logic                           rst,
    output logic                           retire_valid,
    output logic [cpu_pkg::seq_w-1:0]      retire_seq,
    output logic [pc_w-1:0]                retire_pc,
    output logic [cpu_pkg::cycle_w-1:0]    retire_fetch_cycle,
    output logic [cpu_pkg::cycle_w-1:0]    retire_cycle,
    output logic                           retire_we,
    output logic [cpu_pkg::reg_addr_w-1:0] retire_rd,
    output logic [cpu_pkg::xlen-1:0]       retire_data,
    output logic                           halted
);
    import cpu_pkg::*;

    // fetch and redirect
    logic                  if_valid;
    logic [pc_w-1:0]       if_pc;
    logic [xlen-1:0]       if_instr;
    logic                  fetch_fire;
    logic                  stall;
    logic                  branch_taken;
    logic [pc_w-1:0]       branch_target;
    // ID/EX
    logic                  id_valid;
    opcode_t               id_op;
    logic [reg_addr_w-1:0] id_rd;
    logic [reg_addr_w-1:0] id_rs1;
    logic [reg_addr_w-1:0] id_rs2;
    logic [xlen-1:0]       id_rs1_data;
    logic [xlen-1:0]       id_rs2_data;
    logic [xlen-1:0]       id_imm;
    logic [pc_w-1:0]       id_pc;
    // EX/MEM
    logic                  ex_valid;
    opcode_t               ex_op;
    logic [reg_addr_w-1:0] ex_rd;
    logic [xlen-1:0]       ex_result;
    logic [xlen-1:0]       ex_store_data;
    logic [pc_w-1:0]       ex_pc;
    // MEM/WB
    logic                  wb_valid;
    opcode_t               wb_op;
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_data;
    logic [pc_w-1:0]       wb_pc;
    logic                  wb_we;
    logic                  halt_retire;
    logic                  halt_q;

    fetch_stage #(.imem_words(imem_words), .pc_w(pc_w)) fetch_i (.*);

    decode_stage #(.pc_w(pc_w)) decode_i (
        .ex_valid_in (id_valid),
        .ex_op_in    (id_op),
        .ex_rd_in    (id_rd),
        .*
    );

    execute_stage #(.pc_w(pc_w)) execute_i (
        .mem_fwd_valid (ex_valid),
        .mem_fwd_rd    (ex_rd),
        .mem_fwd_data  (ex_result),
        .wb_fwd_valid  (wb_we),
        .wb_fwd_rd     (wb_rd),
        .wb_fwd_data   (wb_data),
        .*
    );

    mem_wb_stage #(.pc_w(pc_w), .dmem_words(dmem_words)) mem_wb_i (.*);

    pipeline_trace trace_i (.*);

    assign retire_pc   = wb_pc;
    assign retire_we   = wb_we;
    assign retire_rd   = wb_rd;
    assign retire_data = wb_data;

    // halted is already high in the cycle the halt retires
    assign halt_retire = wb_valid && wb_op == op_halt;
    assign halted      = halt_q || halt_retire;

    always_ff @(posedge clk) begin
        if (rst) begin
            halt_q <= 1'b0;
        end else if (halt_retire) begin
            halt_q <= 1'b1;
        end
    end

endmodule

/* cpu_properties.sv */
`timescale 1ns/1ps

module cpu_properties (
    input logic                           clk,
    input logic                           rst,
    input logic                           retire_valid,
    input logic [cpu_pkg::cycle_w-1:0]    retire_fetch_cycle,
    input logic [cpu_pkg::cycle_w-1:0]    retire_cycle,
    input logic                           retire_we,
    input logic [cpu_pkg::reg_addr_w-1:0] retire_rd,
    input logic                           halted
);

    no_retire_in_reset: assert property (@(posedge clk) rst |-> !retire_valid)
        else $error("retire_valid high during reset");

    retire_after_fetch: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> retire_cycle > retire_fetch_cycle)
        else $error("retire cycle not after fetch cycle");

    // halted is sticky until reset
    halt_sticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
        else $error("halted dropped");

    no_r0_write: assert property (@(posedge clk) !(retire_we && retire_rd == '0))
        else $error("write enable with rd zero");

endmodule

bind cpu_top cpu_properties props_i (.*);

/* cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int imem_words = 64;
    localparam int dmem_words = 64;
    localparam int pc_w       = $clog2(imem_words);
    localparam int prog_words = 16;
    // reset and fill, then four cycles per program word, with margin
    localparam int max_cycles = (40 + 4 * prog_words) * 3;

    logic                  clk;
    logic                  rst;
    logic                  retire_valid;
    logic [seq_w-1:0]      retire_seq;
    logic [pc_w-1:0]       retire_pc;
    logic [cycle_w-1:0]    retire_fetch_cycle;
    logic [cycle_w-1:0]    retire_cycle;
    logic                  retire_we;
    logic [reg_addr_w-1:0] retire_rd;
    logic [xlen-1:0]       retire_data;
    logic                  halted;

    // ISA model state
    logic [xlen-1:0]       imem [imem_words];
    logic [xlen-1:0]       model_regs [1 << reg_addr_w];
    logic [xlen-1:0]       model_mem [dmem_words];
    int                    model_pc;
    logic                  prev_load;
    logic [reg_addr_w-1:0] prev_load_rd;
    int                    cycle_count;

    cpu_top #(.imem_words(imem_words), .dmem_words(dmem_words)) cpu_top_i (.*);

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic word_check(input string name, input logic [xlen-1:0] got,
                              input logic [xlen-1:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp));
        end
    endtask

    task automatic reg_check(input string name, input logic [reg_addr_w-1:0] got,
                             input logic [reg_addr_w-1:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("MISMATCH t=%0t %s got %0d exp %0d", $time, name, got, exp));
        end
    endtask

    task automatic seq_check(input string name, input logic [seq_w-1:0] got,
                             input logic [seq_w-1:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("MISMATCH t=%0t %s got %0d exp %0d", $time, name, got, exp));
        end
    endtask

    task automatic cycle_check(input string name, input logic [cycle_w-1:0] got,
                               input logic [cycle_w-1:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("MISMATCH t=%0t %s got %0d exp %0d", $time, name, got, exp));
        end
    endtask

    task automatic flag_check(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("MISMATCH t=%0t %s got %b exp %b", $time, name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // ISA reference stepping one instruction per call
    ////////////////////////////////////////////////////////////

    function automatic void isa_step(output int pc, output logic we,
                                     output logic [reg_addr_w-1:0] rd,
                                     output logic [xlen-1:0] data, output logic taken,
                                     output logic is_halt, output logic stalled);
        logic [xlen-1:0]       instr;
        opcode_t               op;
        logic [reg_addr_w-1:0] f_rd;
        logic [reg_addr_w-1:0] f_rs1;
        logic [reg_addr_w-1:0] f_rs2;
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       sum;
        logic [xlen-1:0]       res;
        logic                  writes;
        logic                  hit;
        instr   = imem[model_pc];
        op      = opcode_t'(instr[op_lsb +: op_w]);
        f_rd    = instr[rd_lsb +: reg_addr_w];
        f_rs1   = instr[rs1_lsb +: reg_addr_w];
        f_rs2   = instr[rs2_lsb +: reg_addr_w];
        imm     = {{(xlen - imm_w){instr[imm_w-1]}}, instr[imm_w-1:0]};
        sum     = model_regs[f_rs1] + imm;
        pc      = model_pc;
        res     = '0;
        writes  = 1'b0;
        taken   = 1'b0;
        is_halt = 1'b0;
        hit     = 1'b0;
        case (op)
            op_add, op_sub, op_and, op_or: hit = f_rs1 == prev_load_rd || f_rs2 == prev_load_rd;
            op_addi, op_lw:                hit = f_rs1 == prev_load_rd;
            op_sw, op_beq:                 hit = f_rs1 == prev_load_rd || f_rd == prev_load_rd;
            default:                       hit = 1'b0;
        endcase
        stalled = prev_load && prev_load_rd != '0 && hit;
        model_pc = (model_pc + 1) % imem_words;
        case (op)
            op_add:  begin res = model_regs[f_rs1] + model_regs[f_rs2]; writes = 1'b1; end
            op_sub:  begin res = model_regs[f_rs1] - model_regs[f_rs2]; writes = 1'b1; end
            op_and:  begin res = model_regs[f_rs1] & model_regs[f_rs2]; writes = 1'b1; end
            op_or:   begin res = model_regs[f_rs1] | model_regs[f_rs2]; writes = 1'b1; end
            op_addi: begin res = sum; writes = 1'b1; end
            op_lw:   begin res = model_mem[sum % dmem_words]; writes = 1'b1; end
            op_sw:   model_mem[sum % dmem_words] = model_regs[f_rd];
            op_beq: begin
                if (model_regs[f_rd] == model_regs[f_rs1]) begin
                    taken    = 1'b1;
                    model_pc = int'(xlen'(pc + 1) + imm) % imem_words;
                end
            end
            op_halt: is_halt = 1'b1;
            default: ;
        endcase
        we   = writes && f_rd != '0;
        rd   = f_rd;
        data = res;
        if (we) begin
            model_regs[f_rd] = res;
        end
        prev_load    = op == op_lw;
        prev_load_rd = f_rd;
    endfunction

    // run limit
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            fail_now("timeout: the program never reached its halt");
        end
    end

    initial begin
        int                    exp_pc;
        logic                  exp_we;
        logic [reg_addr_w-1:0] exp_rd;
        logic [xlen-1:0]       exp_data;
        logic                  exp_taken;
        logic                  exp_halt;
        logic                  exp_stall;
        logic [seq_w-1:0]      exp_seq;
        cycle_count  = 0;
        rst          = 1'b1;
        model_pc     = 0;
        prev_load    = 1'b0;
        prev_load_rd = '0;
        exp_seq      = '0;
        exp_halt     = 1'b0;
        $readmemh("program.hex", imem);
        for (int i = 0; i < (1 << reg_addr_w); i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < dmem_words; i++) begin
            model_mem[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;

        while (!exp_halt) begin
            @(negedge clk);
            if (retire_valid) begin
                isa_step(exp_pc, exp_we, exp_rd, exp_data, exp_taken, exp_halt, exp_stall);
                seq_check("retire_seq", retire_seq, exp_seq);
                word_check("retire_pc", xlen'(retire_pc), xlen'(exp_pc));
                flag_check("retire_we", retire_we, exp_we);
                if (exp_we) begin
                    reg_check("retire_rd", retire_rd, exp_rd);
                    word_check("retire_data", retire_data, exp_data);
                end
                // a load-use victim waits one extra cycle
                cycle_check("retire latency", retire_cycle - retire_fetch_cycle,
                            exp_stall ? cycle_w'(5) : cycle_w'(4));
                flag_check("halted", halted, exp_halt);
                exp_seq = exp_seq + (exp_taken ? seq_w'(3) : seq_w'(1));
            end else begin
                flag_check("halted", halted, 1'b0);
            end
        end

        // nothing may retire after the halt
        repeat (10) begin
            @(negedge clk);
            flag_check("retire_valid", retire_valid, 1'b0);
            flag_check("halted", halted, 1'b1);
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* program.hex */
// one instruction word per line: op[15:12] rd[11:9] rs1[8:6] rs2[5:3] or imm[5:0]
// word 0 first, halt at word 15
5205
5403
1650
28C8
3B08
4D58
7C42
6E07
1FF8
640A
8402
5201
5202
823D
5041
9000

/* all.f */
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
pipeline_trace.sv
cpu_top.sv
cpu_properties.sv
cpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f all.f -o cpu_sim
./obj_dir/cpu_sim
